// File: Makefile
TOP := tb_coresub_ctrl

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "SOME TESTS FAILED" sim.log; then \
		echo "simulation reported failures"; \
		exit 1; \
	fi
	@grep -q "ALL TESTS PASSED" sim.log || (echo "no pass message in sim.log"; exit 1)

clean:
	rm -rf obj_dir sim.log

// File: code_region_map.sv
`timescale 1ns/1ps

module code_region_map import coresub_pkg::*; #(
    parameter core_e CORE = cm7
) (
    input  logic        hclk,
    input  logic        reset,
    input  logic        addr_vld,
    input  addr_t       addr,
    corecfg_if.user     cfg,
    output logic        hit,
    output region_idx_t region
);

    bounds_t                bounds;
    logic                   core_en;
    addr_t                  bound_addr [BOUND_CNT];
    logic [REGION_CNT-1:0]  match;
    logic                   any_match;
    region_idx_t            match_idx;

    assign bounds  = (CORE == cm7) ? cfg.cm7_bounds : cfg.vex_bounds;
    assign core_en = (CORE == cm7) ? cfg.cm7_en : cfg.vex_en;

    // compact bound into the reram window
    always_comb begin
        for (int i = 0; i < BOUND_CNT; i++) begin
            bound_addr[i] = addr_t'({RRAM_WINDOW_HI, bounds[i]}) << RRAM_SHIFT;
        end
    end

    always_comb begin
        for (int i = 0; i < CODEMEM_CNT; i++) begin
            match[i] = (addr >= CODE_MEM_MAP[i][0]) && (addr < CODE_MEM_MAP[i][1]);
        end
        // boot0, boot1, fw0, fw1 each end where the next one starts
        for (int i = 0; i < BOUND_CNT - 1; i++) begin
            match[CODEMEM_CNT+i] = (addr >= bound_addr[i]) && (addr < bound_addr[i+1]);
        end
    end

    // lowest index wins
    always_comb begin
        any_match = 1'b0;
        match_idx = '0;
        for (int i = REGION_CNT - 1; i >= 0; i--) begin
            if (match[i]) begin
                any_match = 1'b1;
                match_idx = region_idx_t'(i);
            end
        end
    end

    always_ff @(posedge hclk) begin
        if (reset) begin
            hit <= 1'b0;
        end else begin
            hit <= addr_vld && any_match && cfg.cfg_valid && core_en;
        end
    end

    always_ff @(posedge hclk) begin
        if (addr_vld) begin
            region <= match_idx;
        end
    end

    // a hit meets a valid config, or the reload that drops it
    a_hit_cfg_valid: assert property (@(posedge hclk) disable iff (reset)
        hit |-> (cfg.cfg_valid || cfg.reload));

endmodule : code_region_map

// File: corecfg_if.sv
`timescale 1ns/1ps

interface corecfg_if import coresub_pkg::*; ();

    logic       cfg_valid;
    // one cycle while a new word is being taken
    logic       reload;
    logic       cm7_en;
    logic       vex_en;
    filtercyc_t filtercyc;
    bounds_t    cm7_bounds;
    bounds_t    vex_bounds;

    modport seq (
        output cfg_valid,
        output reload,
        output cm7_en,
        output vex_en,
        output filtercyc,
        output cm7_bounds,
        output vex_bounds
    );

    modport user (
        input  cfg_valid,
        input  reload,
        input  cm7_en,
        input  vex_en,
        input  filtercyc,
        input  cm7_bounds,
        input  vex_bounds
    );

endinterface : corecfg_if

// File: corecfg_seq.sv
`timescale 1ns/1ps

module corecfg_seq import coresub_pkg::*; (
    input  logic     hclk,
    input  logic     reset,
    input  logic     cfg_load,
    input  nvr_cfg_t cfg_word,
    output logic     cfg_err,
    output logic     cm7_dev,
    output logic     vex_dev,
    corecfg_if.seq   cfg
);

    cfg_state_e state;
    sel_code_t  devena;
    sel_code_t  coresel_cm7;
    sel_code_t  coresel_vex;
    logic       dev_match;
    logic       cm7_sel;
    logic       vex_sel;
    logic       cm7_en_d;
    logic       load_ok;
    logic       bounds_ok;
    logic       cm7_en_q;
    logic       vex_en_q;
    filtercyc_t filtercyc_q;
    bounds_t    cm7_bounds_q;
    bounds_t    vex_bounds_q;

    // code fields sit in the top 12 bits of the word
    assign devena      = cfg_word[99:96];
    assign coresel_cm7 = cfg_word[95:92];
    assign coresel_vex = cfg_word[91:88];

    assign dev_match = (devena == DEVENA_CODE);
    assign cm7_sel   = (coresel_cm7 == CORESEL_CM7_CODE);
    assign vex_sel   = (coresel_vex == CORESEL_VEX_CODE);
    // cm7 runs unless the vex is selected on its own
    assign cm7_en_d  = ~vex_sel | cm7_sel;

    // strobes during load or check are dropped
    assign load_ok = cfg_load && (state == idle || state == ready);

    always_comb begin
        bounds_ok = 1'b1;
        for (int i = 0; i < BOUND_CNT - 1; i++) begin
            if (cm7_bounds_q[i+1] < cm7_bounds_q[i] || vex_bounds_q[i+1] < vex_bounds_q[i]) begin
                bounds_ok = 1'b0;
            end
        end
    end

    always_ff @(posedge hclk) begin
        if (reset) begin
            state    <= idle;
            cfg_err  <= 1'b0;
            cm7_en_q <= 1'b0;
            vex_en_q <= 1'b0;
            cm7_dev  <= 1'b0;
            vex_dev  <= 1'b0;
        end else begin
            cfg_err <= 1'b0;
            if (load_ok) begin
                cm7_en_q <= cm7_en_d;
                vex_en_q <= vex_sel;
                cm7_dev  <= dev_match & cm7_en_d;
                vex_dev  <= dev_match & vex_sel;
            end
            case (state)
                idle, ready: begin
                    if (cfg_load) begin
                        state <= load;
                    end
                end
                load: state <= check;
                check: begin
                    if (bounds_ok) begin
                        state <= ready;
                    end else begin
                        state   <= idle;
                        cfg_err <= 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // region bounds and filter length
    always_ff @(posedge hclk) begin
        if (load_ok) begin
            filtercyc_q  <= cfg_word[87:80];
            cm7_bounds_q <= cfg_word[79:40];
            vex_bounds_q <= cfg_word[39:0];
        end
    end

    assign cfg.cfg_valid  = (state == ready);
    assign cfg.reload     = (state == load);
    assign cfg.cm7_en     = cm7_en_q;
    assign cfg.vex_en     = vex_en_q;
    assign cfg.filtercyc  = filtercyc_q;
    assign cfg.cm7_bounds = cm7_bounds_q;
    assign cfg.vex_bounds = vex_bounds_q;

    // a check ends either valid or in error, never both
    a_valid_err_excl: assert property (@(posedge hclk) disable iff (reset)
        !(cfg.cfg_valid && cfg_err));

endmodule : corecfg_seq

// File: coresub_checker.sv
`timescale 1ns/1ps

module coresub_checker import coresub_pkg::*; (
    input  logic            hclk,
    input  logic            reset,
    input  logic            chk_req,
    input  logic [8*24-1:0] test_name,
    // valid, err seen, cm7_en, vex_en, cm7_dev, vex_dev
    input  logic [5:0]      exp_flags,
    input  coreuser_t       exp_cu_cm7,
    input  coreuser_t       exp_cu_vex,
    input  logic            cfg_valid,
    input  logic            cfg_err,
    input  logic            cm7_en,
    input  logic            vex_en,
    input  logic            cm7_dev,
    input  logic            vex_dev,
    input  coreuser_t       coreuser_cm7,
    input  coreuser_t       coreuser_vex,
    output int              pass_cnt,
    output int              fail_cnt
);

    // any cfg_err pulse since the previous check
    logic err_seen;

    function automatic int field_wrong(input string field, input logic [7:0] exp,
                                       input logic [7:0] act);
        if (act !== exp) begin
            $display("Mismatch %0s %0s expected %0h actual %0h", test_name, field, exp, act);
            return 1;
        end
        return 0;
    endfunction

    task automatic run_check();
        int bad;
        bad = 0;
        bad += field_wrong("cfg_valid", 8'(exp_flags[5]), 8'(cfg_valid));
        bad += field_wrong("cfg_err_seen", 8'(exp_flags[4]), 8'(err_seen | cfg_err));
        bad += field_wrong("cm7_en", 8'(exp_flags[3]), 8'(cm7_en));
        bad += field_wrong("vex_en", 8'(exp_flags[2]), 8'(vex_en));
        bad += field_wrong("cm7_dev", 8'(exp_flags[1]), 8'(cm7_dev));
        bad += field_wrong("vex_dev", 8'(exp_flags[0]), 8'(vex_dev));
        bad += field_wrong("coreuser_cm7", exp_cu_cm7, coreuser_cm7);
        bad += field_wrong("coreuser_vex", exp_cu_vex, coreuser_vex);
        if (bad == 0) begin
            pass_cnt <= pass_cnt + 1;
            $display("test %0s ok", test_name);
        end else begin
            fail_cnt <= fail_cnt + 1;
            $display("test %0s failed with %0d wrong fields", test_name, bad);
        end
    endtask

    always @(posedge hclk) begin
        if (reset) begin
            err_seen <= 1'b0;
            pass_cnt <= 0;
            fail_cnt <= 0;
        end else if (chk_req) begin
            run_check();
            err_seen <= 1'b0;
        end else if (cfg_err) begin
            err_seen <= 1'b1;
        end
    end

endmodule : coresub_checker

// File: coresub_ctrl.sv
`timescale 1ns/1ps

module coresub_ctrl import coresub_pkg::*; (
    input  logic      hclk,
    input  logic      reset,
    input  logic      cfg_load,
    input  nvr_cfg_t  cfg_word,
    input  logic      cm7_addr_vld,
    input  addr_t     cm7_addr,
    input  logic      vex_addr_vld,
    input  addr_t     vex_addr,
    output logic      cfg_valid,
    output logic      cfg_err,
    output logic      cm7_en,
    output logic      vex_en,
    output logic      cm7_dev,
    output logic      vex_dev,
    output coreuser_t coreuser_cm7,
    output coreuser_t coreuser_vex
);

    logic        cm7_hit;
    region_idx_t cm7_region;
    logic        vex_hit;
    region_idx_t vex_region;

    corecfg_if cfg_bus ();

    corecfg_seq corecfg_seq_i (
        .hclk     (hclk),
        .reset    (reset),
        .cfg_load (cfg_load),
        .cfg_word (cfg_word),
        .cfg_err  (cfg_err),
        .cm7_dev  (cm7_dev),
        .vex_dev  (vex_dev),
        .cfg      (cfg_bus.seq)
    );

    // cm7 side
    code_region_map #(.CORE(cm7)) cm7_map_i (
        .hclk     (hclk),
        .reset    (reset),
        .addr_vld (cm7_addr_vld),
        .addr     (cm7_addr),
        .cfg      (cfg_bus.user),
        .hit      (cm7_hit),
        .region   (cm7_region)
    );

    coreuser_filter cm7_filter_i (
        .hclk     (hclk),
        .reset    (reset),
        .hit      (cm7_hit),
        .region   (cm7_region),
        .cfg      (cfg_bus.user),
        .coreuser (coreuser_cm7)
    );

    // vex side
    code_region_map #(.CORE(vex)) vex_map_i (
        .hclk     (hclk),
        .reset    (reset),
        .addr_vld (vex_addr_vld),
        .addr     (vex_addr),
        .cfg      (cfg_bus.user),
        .hit      (vex_hit),
        .region   (vex_region)
    );

    coreuser_filter vex_filter_i (
        .hclk     (hclk),
        .reset    (reset),
        .hit      (vex_hit),
        .region   (vex_region),
        .cfg      (cfg_bus.user),
        .coreuser (coreuser_vex)
    );

    assign cfg_valid = cfg_bus.cfg_valid;
    assign cm7_en    = cfg_bus.cm7_en;
    assign vex_en    = cfg_bus.vex_en;

endmodule : coresub_ctrl

// File: coresub_input.txt
# L <config word hex> / A <core c or v> <address hex> / I <idle cycles>
# C <test> <cfg_valid> <cfg_err seen> <cm7_en> <vex_en> <cm7_dev> <vex_dev> <coreuser cm7> <coreuser vex>
I 2
C after_reset 0 0 0 0 0 0 00 00
# devena match, cm7 only, filter 0
L A500010204080C010204080C0
C sel_cm7_only 1 0 1 0 1 0 00 00
A c 00000100
A v 00000100
C itcm_cm7_only 1 0 1 0 1 0 01 00
# devena match, both cores selected
L A550010204080C010204080C0
C reload_clears 1 0 1 1 1 1 00 00
A c 61180000
A v 61180000
C sram1_both 1 0 1 1 1 1 08 08
A c 00000010
A v 00000010
C itcm_both 1 0 1 1 1 1 01 01
# fw0 spans 60100000 to 60200000, fw1 ends at 60300000
A c 60100100
C fw0_cm7 1 0 1 1 1 1 40 01
A c 60300000
C fw1_end_cm7 1 0 1 1 1 1 40 01
# devena mismatch, vex only
L 0050010204080C010204080C0
C sel_dev_mismatch 1 0 0 1 0 0 00 00
A c 60100100
A v 60100100
C fw0_vex_only 1 0 0 1 0 0 00 40
# vex fw0 start below boot1
L A550010204080C010201080C0
C bad_bounds 0 1 1 1 1 1 00 00
A c 00000100
A v 61180000
C bad_bounds_addr 0 0 1 1 1 1 00 00
# filter length 3
L A550310204080C010204080C0
C filt_load 1 0 1 1 1 1 00 00
A c 00000100
A c 00000100
A c 00000100
C filt_three 1 0 1 1 1 1 00 00
A c 00000100
C filt_fourth 1 0 1 1 1 1 01 00
A c 61180000
A c 61180000
A c 61180000
A c 00000100
A c 61180000
A c 61180000
A c 61180000
C filt_restart 1 0 1 1 1 1 01 00
A c 61180000
C filt_switch 1 0 1 1 1 1 08 00

// File: coresub_pkg.sv
package coresub_pkg;

    // region layout of each core's code space
    localparam int REGION_CNT  = 8;
    localparam int CODEMEM_CNT = 4;
    localparam int BOUND_CNT   = 5;

    // compact reram address expansion
    localparam logic [9:0] RRAM_WINDOW_HI = 10'b0110000000;
    localparam int         RRAM_SHIFT     = 14;

    typedef logic [31:0]           addr_t;
    typedef logic [7:0]            cmpt_addr_t;
    typedef logic [2:0]            region_idx_t;
    typedef logic [REGION_CNT-1:0] coreuser_t;
    typedef logic [7:0]            filtercyc_t;
    typedef logic [3:0]            sel_code_t;

    // devena, coresel_cm7, coresel_vex, filtercyc, cm7 bounds, vex bounds
    typedef logic [99:0] nvr_cfg_t;

    // boot0 start in element 0, fw1 end in the last element
    typedef cmpt_addr_t [0:BOUND_CNT-1] bounds_t;

    typedef enum logic {
        cm7,
        vex
    } core_e;

    typedef enum logic [1:0] {
        idle,
        load,
        check,
        ready
    } cfg_state_e;

    // fixed code memories, start inclusive and end exclusive
    // order is itcm, dtcm, sram0, sram1
    localparam addr_t CODE_MEM_MAP [CODEMEM_CNT][2] = '{
        '{32'h0000_0000, 32'h0001_0000},
        '{32'h2000_0000, 32'h2001_0000},
        '{32'h6100_0000, 32'h6110_0000},
        '{32'h6110_0000, 32'h6120_0000}
    };

    // codes expected in the config word
    localparam sel_code_t DEVENA_CODE      = 4'hA;
    localparam sel_code_t CORESEL_CM7_CODE = 4'h5;
    localparam sel_code_t CORESEL_VEX_CODE = 4'h5;

endpackage : coresub_pkg

// File: coreuser_filter.sv
`timescale 1ns/1ps

module coreuser_filter import coresub_pkg::*; (
    input  logic        hclk,
    input  logic        reset,
    input  logic        hit,
    input  region_idx_t region,
    corecfg_if.user     cfg,
    output coreuser_t   coreuser
);

    region_idx_t cand;
    logic        cand_vld;
    filtercyc_t  cnt;
    filtercyc_t  cnt_next;
    logic        same_region;

    assign same_region = cand_vld && (region == cand);

    // repeat count on the candidate, held at full scale
    always_comb begin
        if (!same_region) begin
            cnt_next = '0;
        end else if (cnt == '1) begin
            cnt_next = cnt;
        end else begin
            cnt_next = cnt + 1'b1;
        end
    end

    always_ff @(posedge hclk) begin
        if (reset || cfg.reload) begin
            cand     <= '0;
            cand_vld <= 1'b0;
            cnt      <= '0;
            coreuser <= '0;
        end else if (hit) begin
            cand     <= region;
            cand_vld <= 1'b1;
            cnt      <= cnt_next;
            // switch once the region has been stable long enough
            if (cnt_next == cfg.filtercyc) begin
                coreuser <= coreuser_t'(1) << region;
            end
        end
    end

    a_coreuser_onehot: assert property (@(posedge hclk) disable iff (reset)
        $onehot0(coreuser));

endmodule : coreuser_filter

// File: filelist.f
coresub_pkg.sv
corecfg_if.sv
corecfg_seq.sv
code_region_map.sv
coreuser_filter.sv
coresub_ctrl.sv
coresub_checker.sv
tb_coresub_ctrl.sv

// File: tb_coresub_ctrl.sv
`timescale 1ns/1ps

module tb_coresub_ctrl import coresub_pkg::*; ();

    logic            hclk;
    logic            reset;
    logic            cfg_load;
    nvr_cfg_t        cfg_word;
    logic            cm7_addr_vld;
    addr_t           cm7_addr;
    logic            vex_addr_vld;
    addr_t           vex_addr;
    logic            cfg_valid;
    logic            cfg_err;
    logic            cm7_en;
    logic            vex_en;
    logic            cm7_dev;
    logic            vex_dev;
    coreuser_t       coreuser_cm7;
    coreuser_t       coreuser_vex;

    logic            chk_req;
    logic [8*24-1:0] test_name;
    logic [5:0]      exp_flags;
    coreuser_t       exp_cu_cm7;
    coreuser_t       exp_cu_vex;
    int              pass_cnt;
    int              fail_cnt;
    int              line_cnt;
    int              checks_sent;
    logic            lines_counted;
    logic            file_err;

    coresub_ctrl coresub_ctrl_i (.*);

    coresub_checker checker_i (.*);

    initial begin
        hclk = 1'b0;
        forever #4 hclk = ~hclk;
    end

    // one cycle on the falling edge, strobes back to idle
    task automatic next_cycle();
        @(negedge hclk);
        cfg_load     = 1'b0;
        cm7_addr_vld = 1'b0;
        vex_addr_vld = 1'b0;
        chk_req      = 1'b0;
    endtask

    task automatic expect_fields(input int got, input int want);
        if (got != want) begin
            $display("error: malformed line in coresub_input.txt, read %0d of %0d fields",
                     got, want);
            file_err = 1'b1;
        end
    endtask

    initial begin
        int               fd;
        int               n;
        int               cycles;
        logic [7:0]       op;
        logic [7:0]       core;
        logic [8*128-1:0] skip;
        logic [8*24-1:0]  name;
        nvr_cfg_t         word;
        addr_t            addr;
        logic             e_valid;
        logic             e_err;
        logic             e_cm7_en;
        logic             e_vex_en;
        logic             e_cm7_dev;
        logic             e_vex_dev;
        coreuser_t        e_cu_cm7;
        coreuser_t        e_cu_vex;

        reset         = 1'b1;
        cfg_load      = 1'b0;
        cfg_word      = '0;
        cm7_addr_vld  = 1'b0;
        cm7_addr      = '0;
        vex_addr_vld  = 1'b0;
        vex_addr      = '0;
        chk_req       = 1'b0;
        test_name     = '0;
        exp_flags     = '0;
        exp_cu_cm7    = '0;
        exp_cu_vex    = '0;
        line_cnt      = 0;
        checks_sent   = 0;
        lines_counted = 1'b0;
        file_err      = 1'b0;

        // first pass only counts lines for the watchdog
        fd = $fopen("coresub_input.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open coresub_input.txt");
            file_err = 1'b1;
        end else begin
            while ($fgets(skip, fd) != 0) begin
                line_cnt++;
            end
            $fclose(fd);
            lines_counted = 1'b1;
            fd = $fopen("coresub_input.txt", "r");
        end

        repeat (16) @(posedge hclk);
        @(negedge hclk);
        reset = 1'b0;

        while (fd != 0 && $fscanf(fd, " %s", op) == 1) begin
            if (op == "#") begin
                void'($fgets(skip, fd));
            end else if (op == "L") begin
                n = $fscanf(fd, " %h", word);
                expect_fields(n, 1);
                next_cycle();
                cfg_load = 1'b1;
                cfg_word = word;
            end else if (op == "A") begin
                n = $fscanf(fd, " %s %h", core, addr);
                expect_fields(n, 2);
                next_cycle();
                if (core == "c") begin
                    cm7_addr_vld = 1'b1;
                    cm7_addr     = addr;
                end else if (core == "v") begin
                    vex_addr_vld = 1'b1;
                    vex_addr     = addr;
                end else begin
                    $display("error: unknown core letter %0s in coresub_input.txt", core);
                    file_err = 1'b1;
                end
            end else if (op == "I") begin
                n = $fscanf(fd, " %d", cycles);
                expect_fields(n, 1);
                repeat (cycles) next_cycle();
            end else if (op == "C") begin
                n = $fscanf(fd, " %s %b %b %b %b %b %b %h %h", name, e_valid, e_err,
                            e_cm7_en, e_vex_en, e_cm7_dev, e_vex_dev, e_cu_cm7, e_cu_vex);
                expect_fields(n, 9);
                // let config and address pipelines settle
                repeat (4) next_cycle();
                next_cycle();
                chk_req    = 1'b1;
                test_name  = name;
                exp_flags  = {e_valid, e_err, e_cm7_en, e_vex_en, e_cm7_dev, e_vex_dev};
                exp_cu_cm7 = e_cu_cm7;
                exp_cu_vex = e_cu_vex;
                checks_sent++;
            end else begin
                $display("error: unknown line type %0s in coresub_input.txt", op);
                file_err = 1'b1;
            end
        end

        repeat (4) next_cycle();
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("tests %0d, passed %0d, failed %0d", checks_sent, pass_cnt, fail_cnt);
        if (!file_err && fail_cnt == 0 && checks_sent > 0 && pass_cnt == checks_sent) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // watchdog, budget scales with the data file
    initial begin
        wait (lines_counted);
        repeat (line_cnt * 64 + 200) @(posedge hclk);
        $display("error: run timed out after %0d cycles", line_cnt * 64 + 200);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule : tb_coresub_ctrl
